//--- src.f
dma_types_pkg.sv
reg_map_pkg.sv
pulse_merge.sv
desc_channel.sv
ctrl_regs.sv
dma_ctrl_top.sv
tb_dma_ctrl_assert.sv
tb_dma_ctrl.sv

//--- Bender.yml
package:
  name: dma_ctrl

sources:
  - dma_types_pkg.sv
  - reg_map_pkg.sv
  - pulse_merge.sv
  - desc_channel.sv
  - ctrl_regs.sv
  - dma_ctrl_top.sv
  - target: test
    files:
      - tb_dma_ctrl_assert.sv
      - tb_dma_ctrl.sv

//--- tb_dma_ctrl.sv
`timescale 1ns/10ps

/*
 * Testbench for the DMA control core: register bus tasks and tests of
 * enable, descriptor launch, status pop, counters and error merge
 */
module tb_dma_ctrl;
    import dma_types_pkg::*;
    import reg_map_pkg::*;

    localparam int timeout_cycles = 64;

    logic         clk;
    logic         rst;
    reg_wr_req_t  wr_req;
    reg_rd_req_t  rd_req;
    logic         wr_done_ack;
    logic         rd_rsp_ack;
    logic         rd_desc_ready;
    logic         wr_desc_ready;
    desc_status_t rd_status;
    desc_status_t wr_status;
    logic         rq_pkt_end;
    logic         rc_pkt_end;
    logic         cq_pkt_end;
    logic         cc_pkt_end;
    err_vec_t     err_cor;
    err_vec_t     err_uncor;
    logic         wr_accept;
    logic         rd_accept;
    logic         wr_done;
    reg_rd_rsp_t  rd_rsp;
    desc_t        rd_desc;
    logic         rd_desc_valid;
    desc_t        wr_desc;
    logic         wr_desc_valid;
    logic         rd_status_ready;
    logic         wr_status_ready;
    logic         dma_enable;
    logic         irq;
    logic         err_cor_pulse;
    logic         err_uncor_pulse;

    integer       seed;
    logic [1:0]   status_ready_seen;
    logic         enable_model;
    int           pkt_model [4];
    int           cor_sent;
    int           uncor_sent;
    int           cor_seen;
    int           uncor_seen;

    dma_ctrl_top #(.ERR_COUNT_WIDTH(4)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else
            fail_now($sformatf("mismatch in %s: expected %0h, actual %0h",
                               test, expected, actual));
    endtask

    task automatic tick_or_timeout(inout int cycles, input string what);
        @(posedge clk);
        cycles++;
        if (cycles > timeout_cycles) begin
            fail_now({"timeout while waiting for ", what});
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        int cycles;
        @(posedge clk);
        wr_req <= '{addr: addr, data: data, valid: 1'b1};
        cycles = 0;
        do begin
            tick_or_timeout(cycles, "write accept");
        end while (!wr_accept);
        wr_req.valid <= 1'b0;
        wr_done_ack  <= 1'b1;
        cycles = 0;
        do begin
            tick_or_timeout(cycles, "write done to clear");
        end while (wr_done);
        wr_done_ack <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        int cycles;
        @(posedge clk);
        rd_req <= '{addr: addr, valid: 1'b1};
        cycles = 0;
        do begin
            tick_or_timeout(cycles, "read accept");
        end while (!rd_accept);
        data = rd_rsp.data;
        // status ready pulses alongside the accept
        status_ready_seen = {rd_status_ready, wr_status_ready};
        rd_req.valid <= 1'b0;
        rd_rsp_ack   <= 1'b1;
        cycles = 0;
        do begin
            tick_or_timeout(cycles, "read response to clear");
        end while (rd_rsp.valid);
        rd_rsp_ack <= 1'b0;
    endtask

    task automatic enable_readback();
        reg_data_t value;
        reg_data_t rdata;
        repeat (4) begin
            value = $random(seed);
            write_reg(reg_dma_enable, value);
            enable_model = value[0];
            read_reg(reg_dma_enable, rdata);
            check_value("enable readback", enable_model, rdata);
            check_value("enable output", enable_model, dma_enable);
        end
    endtask

    task automatic descriptor_launch(input bit is_wr);
        reg_addr_t base;
        desc_t     exp;
        int        hold;
        int        cycles;
        base          = is_wr ? reg_wr_chan_base : reg_rd_chan_base;
        exp.pcie_addr = {$random(seed), $random(seed)};
        exp.axi_addr  = $random(seed);
        exp.len       = $random(seed);
        exp.tag       = $random(seed);
        write_reg(base | desc_pcie_lo, exp.pcie_addr[31:0]);
        write_reg(base | desc_pcie_hi, exp.pcie_addr[63:32]);
        write_reg(base | desc_axi, exp.axi_addr);
        write_reg(base | desc_len, 32'(exp.len));
        write_reg(base | desc_tag, 32'(exp.tag));
        hold = 1 + ($random(seed) & 7);
        // descriptor waits while ready is low
        repeat (hold) begin
            @(posedge clk);
            check_value("descriptor valid held", 1'b1, is_wr ? wr_desc_valid : rd_desc_valid);
            check_value("descriptor fields", exp, is_wr ? wr_desc : rd_desc);
            check_value("other channel idle", 1'b0, is_wr ? rd_desc_valid : wr_desc_valid);
        end
        if (is_wr) begin
            wr_desc_ready <= 1'b1;
        end else begin
            rd_desc_ready <= 1'b1;
        end
        cycles = 0;
        do begin
            tick_or_timeout(cycles, "descriptor valid to drop");
        end while (is_wr ? wr_desc_valid : rd_desc_valid);
        rd_desc_ready <= 1'b0;
        wr_desc_ready <= 1'b0;
    endtask

    task automatic status_pop(input bit is_wr);
        reg_addr_t    addr;
        desc_status_t st;
        reg_data_t    rdata;
        addr = (is_wr ? reg_wr_chan_base : reg_rd_chan_base) | desc_status;
        for (int v = 1; v >= 0; v--) begin
            st = '{tag: 8'($random(seed)), valid: v[0]};
            if (is_wr) begin
                wr_status <= st;
            end else begin
                rd_status <= st;
            end
            read_reg(addr, rdata);
            check_value("status word", {v[0], 23'b0, st.tag}, rdata);
            check_value("status ready pulse", {v[0] && !is_wr, v[0] && is_wr},
                        status_ready_seen);
            check_value("irq", rd_status.valid || wr_status.valid, irq);
        end
    endtask

    task automatic packet_counters();
        reg_data_t  rdata;
        logic [3:0] strobes;
        repeat (40) begin
            @(posedge clk);
            strobes = $random(seed);
            {cc_pkt_end, cq_pkt_end, rc_pkt_end, rq_pkt_end} <= strobes;
            for (int i = 0; i < 4; i++) begin
                pkt_model[i] += int'(strobes[i]);
            end
        end
        @(posedge clk);
        {cc_pkt_end, cq_pkt_end, rc_pkt_end, rq_pkt_end} <= 4'b0;
        for (int i = 0; i < 4; i++) begin
            read_reg(reg_cnt_rq + 16'(4 * i), rdata);
            check_value("packet counter", pkt_model[i], rdata);
        end
    endtask

    task automatic error_merge();
        err_vec_t cor;
        err_vec_t uncor;
        int       cycles;
        // a quiet cycle after each burst keeps the count below saturation
        repeat (8) begin
            @(posedge clk);
            cor   = $random(seed);
            uncor = $random(seed);
            err_cor    <= cor;
            err_uncor  <= uncor;
            cor_sent   += $countones(cor);
            uncor_sent += $countones(uncor);
            @(posedge clk);
            err_cor   <= '0;
            err_uncor <= '0;
        end
        cycles = 0;
        do begin
            tick_or_timeout(cycles, "error pulses to drain");
        end while (err_cor_pulse || err_uncor_pulse ||
                   cor_seen < cor_sent || uncor_seen < uncor_sent);
        check_value("correctable pulse count", cor_sent, cor_seen);
        check_value("uncorrectable pulse count", uncor_sent, uncor_seen);
    endtask

    task automatic unknown_offset();
        reg_data_t rdata;
        read_reg(16'h0300, rdata);
        check_value("unknown offset read", 0, rdata);
        read_reg(16'h0120, rdata);
        check_value("unknown channel field read", 0, rdata);
        // bit 0 opposite to the current enable
        write_reg(16'h0300, {31'($random(seed)), ~enable_model});
        write_reg(16'h0120, $random(seed));
        // unknown window at the tag field offset
        write_reg(16'h0314, $random(seed));
        read_reg(reg_dma_enable, rdata);
        check_value("enable after unknown write", enable_model, rdata);
        read_reg(reg_cnt_cc, rdata);
        check_value("counter after unknown write", pkt_model[3], rdata);
        check_value("no launch on unknown write", 2'b00, {rd_desc_valid, wr_desc_valid});
    endtask

    // merged pulse counts update after the edge
    always @(posedge clk) begin
        if (!rst && err_cor_pulse) begin
            cor_seen <= cor_seen + 1;
        end
        if (!rst && err_uncor_pulse) begin
            uncor_seen <= uncor_seen + 1;
        end
    end

    always @(posedge clk) begin
        if (u_dut.u_assert.assert_errors != 0) begin
            fail_now("a protocol assertion on dma_ctrl_top failed");
        end
    end

    initial begin
        seed          = 16;
        rst           = 1'b1;
        wr_req        = '0;
        rd_req        = '0;
        wr_done_ack   = 1'b0;
        rd_rsp_ack    = 1'b0;
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        rd_status     = '0;
        wr_status     = '0;
        rq_pkt_end    = 1'b0;
        rc_pkt_end    = 1'b0;
        cq_pkt_end    = 1'b0;
        cc_pkt_end    = 1'b0;
        err_cor       = '0;
        err_uncor     = '0;
        enable_model  = 1'b0;
        cor_sent      = 0;
        uncor_sent    = 0;
        cor_seen      = 0;
        uncor_seen    = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        enable_readback();
        descriptor_launch(1'b0);
        descriptor_launch(1'b1);
        status_pop(1'b0);
        status_pop(1'b1);
        packet_counters();
        error_merge();
        unknown_offset();
        if (u_dut.u_assert.assert_errors != 0) begin
            fail_now("a protocol assertion on dma_ctrl_top failed");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- tb_dma_ctrl_assert.sv
`timescale 1ns/10ps

/*
 * Protocol assertions for the DMA control core, bound to its top level
 */
module tb_dma_ctrl_assert (
    input logic                        clk,
    input logic                        rst,
    input logic                        wr_accept,
    input logic                        wr_done,
    input logic                        wr_done_ack,
    input reg_map_pkg::reg_rd_rsp_t    rd_rsp,
    input logic                        rd_rsp_ack,
    input dma_types_pkg::desc_t        rd_desc,
    input logic                        rd_desc_valid,
    input logic                        rd_desc_ready,
    input dma_types_pkg::desc_t        wr_desc,
    input logic                        wr_desc_valid,
    input logic                        wr_desc_ready,
    input dma_types_pkg::desc_status_t rd_status,
    input dma_types_pkg::desc_status_t wr_status,
    input logic                        rd_status_ready,
    input logic                        wr_status_ready,
    input logic                        err_cor_pulse,
    input logic                        err_uncor_pulse
);
    int assert_errors = 0;

    // accept and done rise on the same edge
    accept_then_done: assert property (@(posedge clk) disable iff (rst)
        wr_accept |-> wr_done)
    else begin
        assert_errors++;
        $error("wr_accept seen without wr_done");
    end

    done_holds: assert property (@(posedge clk) disable iff (rst)
        wr_done && !wr_done_ack |=> wr_done)
    else begin
        assert_errors++;
        $error("wr_done dropped before wr_done_ack");
    end

    rsp_holds: assert property (@(posedge clk) disable iff (rst)
        rd_rsp.valid && !rd_rsp_ack |=> rd_rsp.valid && $stable(rd_rsp.data))
    else begin
        assert_errors++;
        $error("rd_rsp changed before rd_rsp_ack");
    end

    rd_desc_holds: assert property (@(posedge clk) disable iff (rst)
        rd_desc_valid && !rd_desc_ready |=> rd_desc_valid && $stable(rd_desc))
    else begin
        assert_errors++;
        $error("rd_desc changed before rd_desc_ready");
    end

    wr_desc_holds: assert property (@(posedge clk) disable iff (rst)
        wr_desc_valid && !wr_desc_ready |=> wr_desc_valid && $stable(wr_desc))
    else begin
        assert_errors++;
        $error("wr_desc changed before wr_desc_ready");
    end

    // one cycle wide and only for a valid status
    rd_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        rd_status_ready |-> $past(rd_status.valid) ##1 !rd_status_ready)
    else begin
        assert_errors++;
        $error("bad rd_status_ready pulse");
    end

    wr_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        wr_status_ready |-> $past(wr_status.valid) ##1 !wr_status_ready)
    else begin
        assert_errors++;
        $error("bad wr_status_ready pulse");
    end

    quiet_in_reset: assert property (@(posedge clk)
        rst |=> !err_cor_pulse && !err_uncor_pulse)
    else begin
        assert_errors++;
        $error("merged error pulse during reset");
    end

endmodule

bind dma_ctrl_top tb_dma_ctrl_assert u_assert (.*);

//--- dma_ctrl_top.sv
`timescale 1ns/10ps

/*
 * DMA endpoint control core: register slave, read and write
 * descriptor channels and the two error pulse mergers
 */
module dma_ctrl_top #(
    parameter int ERR_COUNT_WIDTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  reg_map_pkg::reg_wr_req_t    wr_req,
    input  reg_map_pkg::reg_rd_req_t    rd_req,
    input  logic                        wr_done_ack,
    input  logic                        rd_rsp_ack,
    input  logic                        rd_desc_ready,
    input  logic                        wr_desc_ready,
    input  dma_types_pkg::desc_status_t rd_status,
    input  dma_types_pkg::desc_status_t wr_status,
    input  logic                        rq_pkt_end,
    input  logic                        rc_pkt_end,
    input  logic                        cq_pkt_end,
    input  logic                        cc_pkt_end,
    input  dma_types_pkg::err_vec_t     err_cor,
    input  dma_types_pkg::err_vec_t     err_uncor,
    output logic                        wr_accept,
    output logic                        rd_accept,
    output logic                        wr_done,
    output reg_map_pkg::reg_rd_rsp_t    rd_rsp,
    output dma_types_pkg::desc_t        rd_desc,
    output logic                        rd_desc_valid,
    output dma_types_pkg::desc_t        wr_desc,
    output logic                        wr_desc_valid,
    output logic                        rd_status_ready,
    output logic                        wr_status_ready,
    output logic                        dma_enable,
    output logic                        irq,
    output logic                        err_cor_pulse,
    output logic                        err_uncor_pulse
);
    import dma_types_pkg::*;
    import reg_map_pkg::*;

    logic        rd_field_we;
    logic        wr_field_we;
    desc_field_t field_sel;
    reg_data_t   field_data;
    logic        rd_status_pop;
    logic        wr_status_pop;
    reg_data_t   rd_status_word;
    reg_data_t   wr_status_word;

    ctrl_regs u_regs (
        .clk            (clk),
        .rst            (rst),
        .wr_req         (wr_req),
        .rd_req         (rd_req),
        .wr_done_ack    (wr_done_ack),
        .rd_rsp_ack     (rd_rsp_ack),
        .rq_pkt_end     (rq_pkt_end),
        .rc_pkt_end     (rc_pkt_end),
        .cq_pkt_end     (cq_pkt_end),
        .cc_pkt_end     (cc_pkt_end),
        .rd_status_word (rd_status_word),
        .wr_status_word (wr_status_word),
        .wr_accept      (wr_accept),
        .rd_accept      (rd_accept),
        .wr_done        (wr_done),
        .rd_rsp         (rd_rsp),
        .dma_enable     (dma_enable),
        .irq            (irq),
        .rd_field_we    (rd_field_we),
        .wr_field_we    (wr_field_we),
        .field_sel      (field_sel),
        .field_data     (field_data),
        .rd_status_pop  (rd_status_pop),
        .wr_status_pop  (wr_status_pop)
    );

    desc_channel u_rd_chan (
        .clk          (clk),
        .rst          (rst),
        .field_we     (rd_field_we),
        .field_sel    (field_sel),
        .field_data   (field_data),
        .status_pop   (rd_status_pop),
        .desc_ready   (rd_desc_ready),
        .status       (rd_status),
        .desc         (rd_desc),
        .desc_valid   (rd_desc_valid),
        .status_word  (rd_status_word),
        .status_ready (rd_status_ready)
    );

    desc_channel u_wr_chan (
        .clk          (clk),
        .rst          (rst),
        .field_we     (wr_field_we),
        .field_sel    (field_sel),
        .field_data   (field_data),
        .status_pop   (wr_status_pop),
        .desc_ready   (wr_desc_ready),
        .status       (wr_status),
        .desc         (wr_desc),
        .desc_valid   (wr_desc_valid),
        .status_word  (wr_status_word),
        .status_ready (wr_status_ready)
    );

    pulse_merge #(
        .INPUT_COUNT (err_src_count),
        .COUNT_WIDTH (ERR_COUNT_WIDTH)
    ) u_cor_merge (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_cor),
        .pulse_out (err_cor_pulse)
    );

    pulse_merge #(
        .INPUT_COUNT (err_src_count),
        .COUNT_WIDTH (ERR_COUNT_WIDTH)
    ) u_uncor_merge (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_uncor),
        .pulse_out (err_uncor_pulse)
    );

endmodule

//--- ctrl_regs.sv
`timescale 1ns/10ps

/*
 * Control register slave: write and read handshakes, channel field
 * decode, DMA enable, packet counters and the status interrupt
 */
module ctrl_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  reg_map_pkg::reg_wr_req_t wr_req,
    input  reg_map_pkg::reg_rd_req_t rd_req,
    input  logic                     wr_done_ack,
    input  logic                     rd_rsp_ack,
    input  logic                     rq_pkt_end,
    input  logic                     rc_pkt_end,
    input  logic                     cq_pkt_end,
    input  logic                     cc_pkt_end,
    input  reg_map_pkg::reg_data_t   rd_status_word,
    input  reg_map_pkg::reg_data_t   wr_status_word,
    output logic                     wr_accept,
    output logic                     rd_accept,
    output logic                     wr_done,
    output reg_map_pkg::reg_rd_rsp_t rd_rsp,
    output logic                     dma_enable,
    output logic                     irq,
    output logic                     rd_field_we,
    output logic                     wr_field_we,
    output reg_map_pkg::desc_field_t field_sel,
    output reg_map_pkg::reg_data_t   field_data,
    output logic                     rd_status_pop,
    output logic                     wr_status_pop
);
    import reg_map_pkg::*;

    localparam reg_addr_t rd_status_addr = reg_rd_chan_base | reg_addr_t'(desc_status);
    localparam reg_addr_t wr_status_addr = reg_wr_chan_base | reg_addr_t'(desc_status);

    logic       wr_take;
    logic       rd_take;
    reg_addr_t  wr_addr;
    reg_addr_t  rd_addr;
    logic       field_ok;
    logic       rd_valid_q;
    reg_data_t  rd_data_q;
    reg_data_t  rd_data;
    reg_data_t  pkt_cnt [4];
    logic [3:0] pkt_end;

    // a new request waits until the previous one was acknowledged
    assign wr_take = wr_req.valid && !wr_done;
    assign rd_take = rd_req.valid && !rd_valid_q;

    assign wr_addr = {wr_req.addr[15:2], 2'b00};
    assign rd_addr = {rd_req.addr[15:2], 2'b00};

    // only the descriptor fields are writable
    always_comb begin
        case (wr_addr[7:0])
            desc_pcie_lo, desc_pcie_hi, desc_axi, desc_len, desc_tag: field_ok = 1'b1;
            default: field_ok = 1'b0;
        endcase
    end

    assign field_sel   = desc_field_t'(wr_addr[7:0]);
    assign field_data  = wr_req.data;
    assign rd_field_we = wr_take && field_ok && wr_addr[15:8] == reg_rd_chan_base[15:8];
    assign wr_field_we = wr_take && field_ok && wr_addr[15:8] == reg_wr_chan_base[15:8];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_accept  <= 1'b0;
            rd_accept  <= 1'b0;
            wr_done    <= 1'b0;
            rd_valid_q <= 1'b0;
            dma_enable <= 1'b0;
        end else begin
            wr_accept  <= wr_take;
            rd_accept  <= rd_take;
            wr_done    <= wr_take || (wr_done && !wr_done_ack);
            rd_valid_q <= rd_take || (rd_valid_q && !rd_rsp_ack);
            if (wr_take && wr_addr == reg_dma_enable) begin
                dma_enable <= wr_req.data[0];
            end
        end
    end

    assign pkt_end = {cc_pkt_end, cq_pkt_end, rc_pkt_end, rq_pkt_end};

    // counters wrap at 2^32
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                pkt_cnt[i] <= '0;
            end else if (pkt_end[i]) begin
                pkt_cnt[i] <= pkt_cnt[i] + 1'b1;
            end
        end
    end

    // a status read also pops that channel
    always_comb begin
        rd_data       = '0;
        rd_status_pop = 1'b0;
        wr_status_pop = 1'b0;
        case (rd_addr)
            reg_dma_enable: rd_data = reg_data_t'(dma_enable);
            rd_status_addr: begin
                rd_data       = rd_status_word;
                rd_status_pop = rd_take;
            end
            wr_status_addr: begin
                rd_data       = wr_status_word;
                wr_status_pop = rd_take;
            end
            reg_cnt_rq: rd_data = pkt_cnt[0];
            reg_cnt_rc: rd_data = pkt_cnt[1];
            reg_cnt_cq: rd_data = pkt_cnt[2];
            reg_cnt_cc: rd_data = pkt_cnt[3];
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_take) begin
            rd_data_q <= rd_data;
        end
    end

    assign rd_rsp = '{data: rd_data_q, valid: rd_valid_q};

    assign irq = rd_status_word[status_valid_bit] || wr_status_word[status_valid_bit];

endmodule

//--- desc_channel.sv
`timescale 1ns/10ps

/*
 * One DMA descriptor channel: field registers, launch on tag write
 * with valid held until ready, and the status word with its pop
 */
module desc_channel (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       field_we,
    input  reg_map_pkg::desc_field_t   field_sel,
    input  reg_map_pkg::reg_data_t     field_data,
    input  logic                       status_pop,
    input  logic                       desc_ready,
    input  dma_types_pkg::desc_status_t status,
    output dma_types_pkg::desc_t       desc,
    output logic                       desc_valid,
    output reg_map_pkg::reg_data_t     status_word,
    output logic                       status_ready
);
    import dma_types_pkg::*;
    import reg_map_pkg::*;

    always_ff @(posedge clk) begin
        if (field_we) begin
            case (field_sel)
                desc_pcie_lo: desc.pcie_addr[31:0] <= field_data;
                desc_pcie_hi: desc.pcie_addr[pcie_addr_width-1:32] <= field_data;
                desc_axi:     desc.axi_addr <= field_data[axi_addr_width-1:0];
                desc_len:     desc.len <= field_data[len_width-1:0];
                desc_tag:     desc.tag <= field_data[tag_width-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            desc_valid   <= 1'b0;
            status_ready <= 1'b0;
        end else begin
            // tag write launches, or relaunches while still pending
            if (field_we && field_sel == desc_tag) begin
                desc_valid <= 1'b1;
            end else if (desc_ready) begin
                desc_valid <= 1'b0;
            end
            status_ready <= status_pop && status.valid;
        end
    end

    always_comb begin
        status_word                   = '0;
        status_word[tag_width-1:0]    = status.tag;
        status_word[status_valid_bit] = status.valid;
    end

endmodule

//--- pulse_merge.sv
`timescale 1ns/10ps

/*
 * Pulse merger: counts pulses from several inputs into a saturating
 * pending count and drains it as one output pulse per cycle
 */
module pulse_merge #(
    parameter int INPUT_COUNT = 3,
    parameter int COUNT_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INPUT_COUNT-1:0] pulse_in,
    output logic                   pulse_out
);
    localparam int SUM_WIDTH = COUNT_WIDTH + $clog2(INPUT_COUNT + 1);
    localparam logic [SUM_WIDTH-1:0] count_max = {COUNT_WIDTH{1'b1}};

    logic [COUNT_WIDTH-1:0] count;
    logic [SUM_WIDTH-1:0]   total;
    logic [COUNT_WIDTH-1:0] count_next;

    // pending plus this cycle's pulses
    always_comb begin
        total = SUM_WIDTH'(count);
        for (int i = 0; i < INPUT_COUNT; i++) begin
            total = total + SUM_WIDTH'(pulse_in[i]);
        end
        if (total == '0) begin
            count_next = '0;
        end else if (total - 1'b1 > count_max) begin
            count_next = {COUNT_WIDTH{1'b1}};
        end else begin
            count_next = COUNT_WIDTH'(total - 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            pulse_out <= 1'b0;
        end else begin
            count     <= count_next;
            pulse_out <= total != '0;
        end
    end

endmodule

//--- reg_map_pkg.sv
/*
 * Control register map: bus request and response records and the
 * offsets of the enable, descriptor channel and counter registers
 */
package reg_map_pkg;

    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // address and data arrive together
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
        logic      valid;
    } reg_wr_req_t;

    typedef struct packed {
        reg_addr_t addr;
        logic      valid;
    } reg_rd_req_t;

    typedef struct packed {
        reg_data_t data;
        logic      valid;
    } reg_rd_rsp_t;

    localparam reg_addr_t reg_dma_enable   = 16'h0000;
    localparam reg_addr_t reg_rd_chan_base = 16'h0100;
    localparam reg_addr_t reg_wr_chan_base = 16'h0200;

    // offsets inside a channel window
    typedef enum logic [7:0] {
        desc_pcie_lo = 8'h00,
        desc_pcie_hi = 8'h04,
        desc_axi     = 8'h08,
        desc_len     = 8'h10,
        desc_tag     = 8'h14,
        desc_status  = 8'h18
    } desc_field_t;

    localparam reg_addr_t reg_cnt_rq = 16'h0400;
    localparam reg_addr_t reg_cnt_rc = 16'h0404;
    localparam reg_addr_t reg_cnt_cq = 16'h0408;
    localparam reg_addr_t reg_cnt_cc = 16'h040C;

    localparam int status_valid_bit = 31;

endpackage

//--- dma_types_pkg.sv
/*
 * DMA descriptor types: field widths, the descriptor and status
 * records exchanged with the DMA engine, and the error pulse vector
 */
package dma_types_pkg;

    localparam int pcie_addr_width = 64;
    localparam int axi_addr_width  = 32;
    localparam int len_width       = 16;
    localparam int tag_width       = 8;

    // correctable and uncorrectable error sources per class
    localparam int err_src_count = 3;

    typedef struct packed {
        logic [pcie_addr_width-1:0] pcie_addr;
        logic [axi_addr_width-1:0]  axi_addr;
        logic [len_width-1:0]       len;
        logic [tag_width-1:0]       tag;
    } desc_t;

    // completion status held by the engine until popped
    typedef struct packed {
        logic [tag_width-1:0] tag;
        logic                 valid;
    } desc_status_t;

    typedef logic [err_src_count-1:0] err_vec_t;

endpackage
